//--- hw/mem_op_pkg.sv
package mem_op_pkg;

    // pipeline data widths
    parameter int XLEN   = 64;                  // data word
    parameter int ADDR_W = 32;                  // byte address
    parameter int OFF_W  = $clog2(XLEN / 8);    // byte offset inside a word

    // funct3 of RISC-V loads and stores
    typedef enum logic [2:0] {
        op_b  = 3'd0,   // lb / sb
        op_h  = 3'd1,   // lh / sh
        op_w  = 3'd2,   // lw / sw
        op_d  = 3'd3,   // ld / sd
        op_bu = 3'd4,   // lbu
        op_hu = 3'd5,   // lhu
        op_wu = 3'd6    // lwu
    } mem_op_t;

    // stores only ever use op_b..op_d

endpackage

//--- hw/dcache_pkg.sv
package dcache_pkg;

    // default geometry of the direct-mapped cache
    parameter int DEF_LINES      = 16;  // lines, power of two
    parameter int DEF_LINE_WORDS = 4;   // 64-bit words per line, power of two

    // controller sequence
    // idle -> lookup -> done on a hit
    // idle -> lookup -> (wb) -> refill -> lookup -> done on a miss
    typedef enum logic [2:0] {
        s_idle   = 3'd0,    // wait for a request
        s_lookup = 3'd1,    // tag compare on registered array read
        s_wb     = 3'd2,    // write back dirty victim
        s_refill = 3'd3,    // fetch the line
        s_done   = 3'd4     // hold result until execute accepts
    } ctrl_state_t;

endpackage

//--- hw/load_store_align.sv
`timescale 1ns/1ps

module load_store_align (
    input  mem_op_pkg::mem_op_t             func3_i,
    input  logic [mem_op_pkg::OFF_W-1:0]    byte_off_i,
    input  logic [mem_op_pkg::XLEN-1:0]     word_i,
    input  logic [mem_op_pkg::XLEN-1:0]     wdata_i,
    output logic [mem_op_pkg::XLEN-1:0]     store_word_o,
    output logic [mem_op_pkg::XLEN-1:0]     load_data_o
);
    import mem_op_pkg::*;

    logic [OFF_W+2:0]  shamt;       // byte offset in bits
    logic [XLEN/8-1:0] size_en;     // bytes touched at offset 0
    logic [XLEN/8-1:0] byte_en;
    logic [XLEN-1:0]   bit_mask;
    logic [XLEN-1:0]   wdata_sh;
    logic [XLEN-1:0]   word_sh;

    assign shamt = {byte_off_i, 3'b000};

    always_comb begin
        case (func3_i)
            op_b, op_bu: size_en = 8'h01;
            op_h, op_hu: size_en = 8'h03;
            op_w, op_wu: size_en = 8'h0f;
            default:     size_en = 8'hff;
        endcase
    end

    assign byte_en = size_en << byte_off_i;

    always_comb begin
        for (int i = 0; i < XLEN / 8; i++) begin
            bit_mask[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    // store merge, only the addressed bytes change
    assign wdata_sh     = wdata_i << shamt;
    assign store_word_o = (word_i & ~bit_mask) | (wdata_sh & bit_mask);

    // load extract, addressed bytes moved to bit 0
    assign word_sh = word_i >> shamt;

    always_comb begin
        case (func3_i)
            op_b:    load_data_o = {{(XLEN-8){word_sh[7]}}, word_sh[7:0]};
            op_h:    load_data_o = {{(XLEN-16){word_sh[15]}}, word_sh[15:0]};
            op_w:    load_data_o = {{(XLEN-32){word_sh[31]}}, word_sh[31:0]};
            op_bu:   load_data_o = {{(XLEN-8){1'b0}}, word_sh[7:0]};
            op_hu:   load_data_o = {{(XLEN-16){1'b0}}, word_sh[15:0]};
            op_wu:   load_data_o = {{(XLEN-32){1'b0}}, word_sh[31:0]};
            default: load_data_o = word_sh;    // ld
        endcase
    end

endmodule

//--- hw/access_counter.sv
`timescale 1ns/1ps

module access_counter (
    input  logic        clk,
    input  logic        rst,
    input  logic        hit_i,          // one cycle per decided hit
    input  logic        miss_i,         // one cycle per decided miss
    output logic [63:0] cache_hit_o,
    output logic [63:0] cache_miss_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_hit_o  <= 64'd0;
            cache_miss_o <= 64'd0;
        end else begin
            if (hit_i) begin
                cache_hit_o <= cache_hit_o + 64'd1;
            end
            if (miss_i) begin
                cache_miss_o <= cache_miss_o + 64'd1;
            end
        end
    end

endmodule

//--- hw/dcache_array.sv
`timescale 1ns/1ps

module dcache_array #(
    parameter int  NUM_LINES  = dcache_pkg::DEF_LINES,
    parameter int  LINE_WORDS = dcache_pkg::DEF_LINE_WORDS,
    localparam int IDX_W      = $clog2(NUM_LINES),
    localparam int WS_W       = $clog2(LINE_WORDS),
    localparam int TAG_W      = mem_op_pkg::ADDR_W - IDX_W - WS_W - mem_op_pkg::OFF_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [IDX_W-1:0]            index_i,
    input  logic [WS_W-1:0]             word_sel_i,
    input  logic                        wr_en_i,
    input  logic [mem_op_pkg::XLEN-1:0] wr_word_i,
    input  logic [TAG_W-1:0]            set_tag_i,      // tag written by the last fill beat
    input  logic                        set_dirty_i,    // store write, otherwise fill write
    output logic [TAG_W-1:0]            tag_o,
    output logic                        valid_o,
    output logic                        dirty_o,
    output logic [mem_op_pkg::XLEN-1:0] line_word_o
);
    import mem_op_pkg::*;

    logic [XLEN-1:0]       data_mem [NUM_LINES*LINE_WORDS];
    logic [TAG_W-1:0]      tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0]  valid_q;
    logic [NUM_LINES-1:0]  dirty_q;
    logic [IDX_W+WS_W-1:0] waddr;
    logic                  fill_done;

    assign waddr = {index_i, word_sel_i};

    // a fill write to the last word completes the line
    assign fill_done = wr_en_i && !set_dirty_i && (word_sel_i == WS_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            data_mem[waddr] <= wr_word_i;
        end
        if (fill_done) begin
            tag_mem[index_i] <= set_tag_i;
        end
        line_word_o <= data_mem[waddr];     // read before write
        tag_o       <= tag_mem[index_i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            valid_o <= 1'b0;
            dirty_o <= 1'b0;
        end else begin
            if (fill_done) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0;   // fresh line is clean
            end else if (wr_en_i && set_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end
            valid_o <= valid_q[index_i];
            dirty_o <= dirty_q[index_i];
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int  NUM_LINES  = dcache_pkg::DEF_LINES,
    parameter int  LINE_WORDS = dcache_pkg::DEF_LINE_WORDS,
    localparam int IDX_W      = $clog2(NUM_LINES),
    localparam int WS_W       = $clog2(LINE_WORDS),
    localparam int TAG_W      = mem_op_pkg::ADDR_W - IDX_W - WS_W - mem_op_pkg::OFF_W
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_valid_i,
    input  logic                          wen_i,
    input  mem_op_pkg::mem_op_t           func3_i,
    input  logic [mem_op_pkg::ADDR_W-1:0] addr_i,
    input  logic                          ex_ready_i,
    input  logic [TAG_W-1:0]              tag_i,
    input  logic                          valid_i,
    input  logic                          dirty_i,
    input  logic [mem_op_pkg::XLEN-1:0]   line_word_i,
    input  logic [mem_op_pkg::XLEN-1:0]   store_word_i,
    input  logic [mem_op_pkg::XLEN-1:0]   load_data_i,
    input  logic                          r_ready_i,
    input  logic                          r_last_i,
    input  logic [mem_op_pkg::XLEN-1:0]   r_data_i,
    input  logic                          w_ready_i,
    input  logic                          w_last_i,
    output logic                          mem_ready_o,
    output logic [mem_op_pkg::XLEN-1:0]   r_data_o,
    output mem_op_pkg::mem_op_t           op_o,
    output logic [mem_op_pkg::OFF_W-1:0]  byte_off_o,
    output logic [IDX_W-1:0]              index_o,
    output logic [WS_W-1:0]               word_sel_o,
    output logic                          wr_en_o,
    output logic [mem_op_pkg::XLEN-1:0]   wr_word_o,
    output logic [TAG_W-1:0]              set_tag_o,
    output logic                          set_dirty_o,
    output logic                          r_valid_o,
    output logic [mem_op_pkg::ADDR_W-1:0] r_addr_o,
    output logic                          w_valid_o,
    output logic [mem_op_pkg::ADDR_W-1:0] w_addr_o,
    output logic [mem_op_pkg::XLEN-1:0]   w_data_o,
    output logic                          hit_pulse_o,
    output logic                          miss_pulse_o
);
    import mem_op_pkg::*;
    import dcache_pkg::*;

    ctrl_state_t     state_q;
    ctrl_state_t     state_d;
    logic [WS_W-1:0] beat_q;        // burst beat
    logic [WS_W-1:0] beat_d;
    logic            fill_wait_q;   // array read still shows pre-fill contents
    logic            refilled_q;    // request already counted as a miss
    logic [TAG_W-1:0] req_tag;
    logic [WS_W-1:0] req_word;
    logic            hit;
    logic            decide;

    assign req_tag    = addr_i[ADDR_W-1 -: TAG_W];
    assign req_word   = addr_i[OFF_W +: WS_W];
    assign index_o    = addr_i[OFF_W+WS_W +: IDX_W];
    assign op_o       = func3_i;
    assign byte_off_o = addr_i[OFF_W-1:0];

    assign hit    = valid_i && (tag_i == req_tag);
    assign decide = (state_q == s_lookup) && !fill_wait_q;

    always_comb begin
        state_d = state_q;
        beat_d  = beat_q;
        case (state_q)
            s_idle: begin
                if (mem_valid_i && !mem_ready_o) begin
                    state_d = s_lookup;
                end
            end
            s_lookup: begin
                if (!fill_wait_q) begin
                    beat_d = '0;
                    if (hit) begin
                        state_d = s_done;
                    end else if (valid_i && dirty_i) begin
                        state_d = s_wb;     // victim must go out first
                    end else begin
                        state_d = s_refill;
                    end
                end
            end
            s_wb: begin
                if (w_ready_i) begin
                    beat_d = beat_q + 1'b1;
                    if (w_last_i) begin
                        state_d = s_refill;
                        beat_d  = '0;
                    end
                end
            end
            s_refill: begin
                if (r_ready_i) begin
                    beat_d = beat_q + 1'b1;
                    if (r_last_i) begin
                        state_d = s_lookup;
                    end
                end
            end
            s_done: begin
                if (mem_ready_o && ex_ready_i) begin
                    state_d = s_idle;
                end
            end
            default: state_d = s_idle;
        endcase
    end

    // write-back reads one word ahead so w_data_o follows each strobe
    always_comb begin
        if (state_q == s_refill) begin
            word_sel_o = beat_q;
        end else if (state_d == s_wb) begin
            word_sel_o = beat_d;
        end else begin
            word_sel_o = req_word;
        end
    end

    assign wr_en_o     = ((state_q == s_refill) && r_ready_i) || (decide && hit && wen_i);
    assign wr_word_o   = (state_q == s_refill) ? r_data_i : store_word_i;
    assign set_tag_o   = req_tag;
    assign set_dirty_o = (state_q == s_lookup);    // store hit path

    assign r_valid_o = (state_q == s_refill);
    assign r_addr_o  = {req_tag, index_o, {(WS_W+OFF_W){1'b0}}};
    assign w_valid_o = (state_q == s_wb);
    assign w_addr_o  = {tag_i, index_o, {(WS_W+OFF_W){1'b0}}};   // victim line
    assign w_data_o  = line_word_i;

    assign hit_pulse_o  = decide && hit && !refilled_q;
    assign miss_pulse_o = decide && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= s_idle;
            beat_q      <= '0;
            fill_wait_q <= 1'b0;
            refilled_q  <= 1'b0;
            mem_ready_o <= 1'b0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
            if ((state_q == s_refill) && r_ready_i && r_last_i) begin
                fill_wait_q <= 1'b1;
                refilled_q  <= 1'b1;
            end else begin
                if (state_q == s_lookup) begin
                    fill_wait_q <= 1'b0;
                end
                if (decide && hit) begin
                    refilled_q <= 1'b0;
                end
            end
            if (state_q == s_done) begin
                if (!mem_ready_o) begin
                    mem_ready_o <= 1'b1;    // second cycle after sampling
                end else if (ex_ready_i) begin
                    mem_ready_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decide && hit && !wen_i) begin
            r_data_o <= load_data_i;    // held through s_done
        end
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int NUM_LINES  = dcache_pkg::DEF_LINES,
    parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
) (
    input  logic                          clk,
    input  logic                          rst,
    // pipeline side
    input  logic                          mem_valid_i,
    input  logic                          wen_i,
    input  mem_op_pkg::mem_op_t           func3_i,
    input  logic [mem_op_pkg::ADDR_W-1:0] addr_i,
    input  logic [mem_op_pkg::XLEN-1:0]   wdata_i,
    input  logic                          ex_ready_i,
    output logic                          mem_ready_o,
    output logic [mem_op_pkg::XLEN-1:0]   r_data_o,
    // read burst
    output logic                          r_valid_o,
    output logic [mem_op_pkg::ADDR_W-1:0] r_addr_o,
    input  logic                          r_ready_i,
    input  logic                          r_last_i,
    input  logic [mem_op_pkg::XLEN-1:0]   r_data_i,
    // write burst
    output logic                          w_valid_o,
    output logic [mem_op_pkg::ADDR_W-1:0] w_addr_o,
    output logic [mem_op_pkg::XLEN-1:0]   w_data_o,
    input  logic                          w_ready_i,
    input  logic                          w_last_i,
    // performance counters
    output logic [63:0]                   cache_hit_o,
    output logic [63:0]                   cache_miss_o
);
    import mem_op_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int WS_W  = $clog2(LINE_WORDS);
    localparam int TAG_W = ADDR_W - IDX_W - WS_W - OFF_W;

    logic [IDX_W-1:0] index;
    logic [WS_W-1:0]  word_sel;
    logic             wr_en;
    logic [XLEN-1:0]  wr_word;
    logic [TAG_W-1:0] set_tag;
    logic             set_dirty;
    logic [TAG_W-1:0] tag;
    logic             valid;
    logic             dirty;
    logic [XLEN-1:0]  line_word;    // registered array read
    logic [XLEN-1:0]  store_word;
    logic [XLEN-1:0]  load_data;
    mem_op_t          op;
    logic [OFF_W-1:0] byte_off;
    logic             hit_pulse;
    logic             miss_pulse;

    dcache_ctrl #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_valid_i  (mem_valid_i),
        .wen_i        (wen_i),
        .func3_i      (func3_i),
        .addr_i       (addr_i),
        .ex_ready_i   (ex_ready_i),
        .tag_i        (tag),
        .valid_i      (valid),
        .dirty_i      (dirty),
        .line_word_i  (line_word),
        .store_word_i (store_word),
        .load_data_i  (load_data),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .w_ready_i    (w_ready_i),
        .w_last_i     (w_last_i),
        .mem_ready_o  (mem_ready_o),
        .r_data_o     (r_data_o),
        .op_o         (op),
        .byte_off_o   (byte_off),
        .index_o      (index),
        .word_sel_o   (word_sel),
        .wr_en_o      (wr_en),
        .wr_word_o    (wr_word),
        .set_tag_o    (set_tag),
        .set_dirty_o  (set_dirty),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .hit_pulse_o  (hit_pulse),
        .miss_pulse_o (miss_pulse)
    );

    dcache_array #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) u_array (
        .clk         (clk),
        .rst         (rst),
        .index_i     (index),
        .word_sel_i  (word_sel),
        .wr_en_i     (wr_en),
        .wr_word_i   (wr_word),
        .set_tag_i   (set_tag),
        .set_dirty_i (set_dirty),
        .tag_o       (tag),
        .valid_o     (valid),
        .dirty_o     (dirty),
        .line_word_o (line_word)
    );

    load_store_align u_align (
        .func3_i      (op),
        .byte_off_i   (byte_off),
        .word_i       (line_word),
        .wdata_i      (wdata_i),
        .store_word_o (store_word),
        .load_data_o  (load_data)
    );

    access_counter u_counter (
        .clk          (clk),
        .rst          (rst),
        .hit_i        (hit_pulse),
        .miss_i       (miss_pulse),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

endmodule

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_op_pkg::*;
    import dcache_pkg::*;

    localparam int LW          = DEF_LINE_WORDS;
    localparam int LINE_BYTES  = LW * 8;
    localparam int NUM_OPS     = 260;       // all tests together
    localparam int WORST_CYC   = 60;        // dirty miss with widest beat gaps

    logic                clk = 1'b0;
    logic                rst;
    logic                mem_valid_i;
    logic                wen_i;
    mem_op_t             func3_i;
    logic [ADDR_W-1:0]   addr_i;
    logic [XLEN-1:0]     wdata_i;
    logic                ex_ready_i;
    logic                mem_ready_o;
    logic [XLEN-1:0]     r_data_o;
    logic                r_valid_o;
    logic [ADDR_W-1:0]   r_addr_o;
    logic                r_ready_i;
    logic                r_last_i;
    logic [XLEN-1:0]     r_data_i;
    logic                w_valid_o;
    logic [ADDR_W-1:0]   w_addr_o;
    logic [XLEN-1:0]     w_data_o;
    logic                w_ready_i;
    logic                w_last_i;
    logic [63:0]         cache_hit_o;
    logic [63:0]         cache_miss_o;

    int                  seed = 32'h173e;
    logic [63:0]         bus_mem [int];     // word address -> data
    logic [63:0]         shadow_mem [int];
    logic [ADDR_W-1:0]   shadow_tag [DEF_LINES];
    logic                shadow_valid [DEF_LINES];
    longint              exp_hits;
    longint              exp_misses;
    logic [63:0]         exp_data;
    logic                check_pending;
    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  tests_bad;
    int                  test_err_start;
    string               cur_test;

    mem_stage #(
        .NUM_LINES  (DEF_LINES),
        .LINE_WORDS (DEF_LINE_WORDS)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .mem_valid_i  (mem_valid_i),
        .wen_i        (wen_i),
        .func3_i      (func3_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .ex_ready_i   (ex_ready_i),
        .mem_ready_o  (mem_ready_o),
        .r_data_o     (r_data_o),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .w_ready_i    (w_ready_i),
        .w_last_i     (w_last_i),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

    always #50 clk = ~clk;     // 100 ns period

    // initial memory contents, every address bit matters
    function automatic logic [63:0] fill_word(input int wa);
        logic [31:0] a;
        a = wa;
        return {a ^ 32'ha5c3_0f17, (~a) + 32'h1234_5678};
    endfunction

    function automatic logic [63:0] bus_read(input int wa);
        if (bus_mem.exists(wa)) begin
            return bus_mem[wa];
        end
        return fill_word(wa);
    endfunction

    function automatic logic [63:0] shadow_word(input int wa);
        if (shadow_mem.exists(wa)) begin
            return shadow_mem[wa];
        end
        return fill_word(wa);
    endfunction

    function automatic int op_bytes(input mem_op_t op);
        case (op)
            op_b, op_bu: return 1;
            op_h, op_hu: return 2;
            op_w, op_wu: return 4;
            default:     return 8;
        endcase
    endfunction

    // expected load value: pick bytes, then extend by opcode
    function automatic logic [63:0] ref_load(input logic [63:0] word, input mem_op_t op,
                                             input int off);
        int          nb;
        logic [63:0] v;
        nb = op_bytes(op);
        v  = 64'd0;
        for (int i = 0; i < nb; i++) begin
            v[i*8 +: 8] = word[(off+i)*8 +: 8];
        end
        if ((op == op_b || op == op_h || op == op_w) && v[nb*8-1]) begin
            for (int i = nb * 8; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    // direct-mapped lookup against the shadow tag table, then allocate
    function automatic logic predict_and_allocate(input logic [ADDR_W-1:0] addr);
        int          idx;
        logic [31:0] tag;
        logic        hit;
        idx = int'((addr / LINE_BYTES) % DEF_LINES);
        tag = addr / (LINE_BYTES * DEF_LINES);
        hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = tag;
        return hit;
    endfunction

    // counts falling edges until mem_ready_o is seen high
    task automatic wait_ready(output int k);
        k = 0;
        do begin
            @(negedge clk);
            k++;
        end while (!mem_ready_o);
    endtask

    // updates the reference model and returns whether a hit is expected
    task automatic model_op(input logic wen, input mem_op_t op, input logic [ADDR_W-1:0] addr,
                            input logic [63:0] wdata, output logic hit, output logic [63:0] exp);
        int          wa;
        int          off;
        logic [63:0] w;
        wa  = int'(addr >> 3);
        off = int'(addr[2:0]);
        hit = predict_and_allocate(addr);
        if (hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
        end
        w = shadow_word(wa);
        if (wen) begin
            for (int i = 0; i < op_bytes(op); i++) begin
                w[(off+i)*8 +: 8] = wdata[i*8 +: 8];
            end
            shadow_mem[wa] = w;
            exp = 64'd0;
        end else begin
            exp = ref_load(w, op, off);
        end
    endtask

    task automatic run_op(input logic wen, input mem_op_t op, input logic [ADDR_W-1:0] addr,
                          input logic [63:0] wdata);
        logic        hit;
        logic [63:0] exp;
        int          k;
        model_op(wen, op, addr, wdata, hit, exp);
        if (!wen) begin
            exp_data      = exp;
            check_pending = 1'b1;
        end
        @(posedge clk);
        mem_valid_i <= 1'b1;
        wen_i       <= wen;
        func3_i     <= op;
        addr_i      <= addr;
        wdata_i     <= wdata;
        wait_ready(k);
        // sampled at the first edge, ready rises two edges later
        if (hit && (k - 2) != 2) begin
            errors++;
            $display("hit at %h in test %s took %0d cycles instead of 2", addr, cur_test, k - 2);
        end
        @(posedge clk);
        mem_valid_i <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test;
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // every word of the line holding addr, bus memory against shadow memory
    task automatic check_bus_line(input logic [ADDR_W-1:0] addr);
        logic [63:0] exp;
        logic [63:0] act;
        int          base;
        base = int'(addr >> 3) & ~(LW - 1);
        for (int i = 0; i < LW; i++) begin
            exp = shadow_word(base + i);
            act = bus_read(base + i);
            if (act !== exp) begin
                errors++;
                $display("mismatch %s (bus word %h): expected %h actual %h", cur_test,
                         (base + i) * 8, exp, act);
            end
        end
    endtask

    // comparing process, one check per completed load
    always @(negedge clk) begin
        if (mem_ready_o && check_pending) begin
            check_pending = 1'b0;
            checks++;
            if (r_data_o !== exp_data) begin
                errors++;
                $display("mismatch %s: expected %h actual %h", cur_test, exp_data, r_data_o);
            end
        end
    end

    // bus memory, beats spaced by 0 to 3 idle cycles
    initial begin : bus_model
        int          gap;
        logic [31:0] base;
        forever begin
            @(negedge clk);
            if (!rst && r_valid_o) begin
                base = r_addr_o;
                for (int i = 0; i < LW; i++) begin
                    gap = int'($unsigned($random(seed)) % 4);
                    repeat (gap) begin
                        @(posedge clk);
                        r_ready_i <= 1'b0;
                        r_last_i  <= 1'b0;
                    end
                    @(posedge clk);
                    r_ready_i <= 1'b1;
                    r_last_i  <= (i == LW - 1);
                    r_data_i  <= bus_read(int'(base >> 3) + i);
                end
                @(posedge clk);
                r_ready_i <= 1'b0;
                r_last_i  <= 1'b0;
            end else if (!rst && w_valid_o) begin
                base = w_addr_o;
                for (int i = 0; i < LW; i++) begin
                    gap = int'($unsigned($random(seed)) % 4);
                    repeat (gap) begin
                        @(posedge clk);
                        w_ready_i <= 1'b0;
                        w_last_i  <= 1'b0;
                    end
                    @(posedge clk);
                    w_ready_i <= 1'b1;
                    w_last_i  <= (i == LW - 1);
                    @(negedge clk);
                    bus_mem[int'(base >> 3) + i] = w_data_o;    // beat taken at next edge
                end
                @(posedge clk);
                w_ready_i <= 1'b0;
                w_last_i  <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        ctrl_state_t st;
        #(longint'(NUM_OPS) * WORST_CYC * 100 + 100000);
        st = dut.u_ctrl.state_q;
        $display("watchdog expired in test %s, controller state %s", cur_test, st.name());
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic        wen;
        logic        hit;
        mem_op_t     op;
        logic [31:0] addr;
        logic [63:0] held;
        logic [63:0] exp2;
        int          nb;
        int          k;
        rst           = 1'b1;
        mem_valid_i   = 1'b0;
        wen_i         = 1'b0;
        func3_i       = op_b;
        addr_i        = '0;
        wdata_i       = '0;
        ex_ready_i    = 1'b1;
        r_ready_i     = 1'b0;
        r_last_i      = 1'b0;
        r_data_i      = '0;
        w_ready_i     = 1'b0;
        w_last_i      = 1'b0;
        check_pending = 1'b0;
        exp_data      = '0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_bad     = 0;
        exp_hits      = 0;
        exp_misses    = 0;
        for (int i = 0; i < DEF_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        begin_test("load_extend");
        run_op(1'b1, op_d, 32'h100, 64'h8091_a2b3_c4d5_e6f7);
        for (int o = 0; o < 7; o++) begin
            nb = op_bytes(mem_op_t'(o));
            for (int off = 0; off < 8; off += nb) begin
                run_op(1'b0, mem_op_t'(o), 32'h100 + off, 64'd0);
            end
        end
        end_test();

        begin_test("store_sizes");
        run_op(1'b1, op_d, 32'h208, 64'h0123_4567_89ab_cdef);
        run_op(1'b1, op_b, 32'h209, 64'hffff_ffff_ffff_ff5a);
        run_op(1'b1, op_h, 32'h20a, 64'h1111_2222_3333_beef);
        run_op(1'b1, op_w, 32'h20c, 64'h4444_5555_dead_c0de);
        run_op(1'b0, op_d, 32'h208, 64'd0);
        run_op(1'b1, op_b, 32'h216, 64'h77);
        run_op(1'b0, op_d, 32'h210, 64'd0);
        end_test();

        begin_test("dirty_evict");
        run_op(1'b1, op_d, 32'h040, 64'hcafe_f00d_1234_5678);
        run_op(1'b1, op_d, 32'h040 + LINE_BYTES * DEF_LINES, 64'h0bad_beef_8765_4321);
        check_bus_line(32'h040);
        run_op(1'b0, op_d, 32'h040, 64'd0);
        check_bus_line(32'h040 + LINE_BYTES * DEF_LINES);
        end_test();

        begin_test("backpressure");
        run_op(1'b0, op_d, 32'h300, 64'd0);
        model_op(1'b0, op_d, 32'h308, 64'd0, hit, exp_data);
        check_pending = 1'b1;
        @(posedge clk);
        mem_valid_i <= 1'b1;
        wen_i       <= 1'b0;
        func3_i     <= op_d;
        addr_i      <= 32'h308;
        ex_ready_i  <= 1'b0;
        wait_ready(k);
        held = r_data_o;
        model_op(1'b0, op_w, 32'h314, 64'd0, hit, exp2);
        @(posedge clk);
        func3_i <= op_w;
        addr_i  <= 32'h314;     // next request waits behind the stall
        repeat (5) begin
            @(negedge clk);
            if (!mem_ready_o) begin
                errors++;
                $display("mem_ready_o fell while ex_ready_i was low in test %s", cur_test);
            end
            if (r_data_o !== held) begin
                errors++;
                $display("mismatch %s: expected %h actual %h", cur_test, held, r_data_o);
            end
            @(posedge clk);
        end
        ex_ready_i <= 1'b1;
        @(posedge clk);
        exp_data      = exp2;
        check_pending = 1'b1;
        wait_ready(k);
        if (k != 4) begin
            errors++;
            $display("request after release took %0d cycles instead of 2", k - 2);
        end
        @(posedge clk);
        mem_valid_i <= 1'b0;
        end_test();

        begin_test("random_ops");
        for (int n = 0; n < 200; n++) begin
            r   = $unsigned($random(seed));
            wen = r[0];
            if (wen) begin
                op = mem_op_t'(r[2:1]);
            end else begin
                op = (r[4:2] == 3'd7) ? op_d : mem_op_t'(r[4:2]);
            end
            nb   = op_bytes(op);
            addr = {20'd0, r[16:5]} & ~(32'(nb) - 32'd1);
            run_op(wen, op, addr, {$random(seed), $random(seed)});
        end
        @(negedge clk);
        if (cache_hit_o !== 64'(exp_hits)) begin
            errors++;
            $display("mismatch %s hits: expected %0d actual %0d", cur_test, exp_hits, cache_hit_o);
        end
        if (cache_miss_o !== 64'(exp_misses)) begin
            errors++;
            $display("mismatch %s misses: expected %0d actual %0d", cur_test, exp_misses,
                     cache_miss_o);
        end
        end_test();

        $display("summary: %0d tests run, %0d with errors, %0d load checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- mem_stage.f
hw/mem_op_pkg.sv
hw/dcache_pkg.sv
hw/load_store_align.sv
hw/access_counter.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/mem_stage.sv
tb/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# compile and run the mem_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mem_stage.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
